//--- build.f
hw/wishbone_pkg.sv
hw/lsu_pkg.sv
hw/wishbone_if.sv
hw/wb_dual_ram.sv
hw/fetch_unit.sv
hw/load_store_unit.sv
hw/mem_subsys_top.sv
verif/tb_mem_subsys.sv

//--- Makefile
# verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_mem_subsys.sv
`default_nettype none

// directed testbench for the fetch and load/store paths of mem_subsys_top
module tb_mem_subsys
  import wishbone_pkg::*, lsu_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int MEM_BYTES  = 4096;
  localparam int WAIT_LIMIT = 8;

  // test address regions
  localparam wb_addr_t FETCH_BASE   = 32'h0000_0100;
  localparam wb_addr_t REDIR_TARGET = 32'h0000_0130;
  localparam wb_addr_t ALIAS_LOW    = 32'h0000_0200;
  localparam wb_addr_t ALIAS_HIGH   = 32'h0000_1200;
  localparam wb_addr_t MIS_BASE     = 32'h0000_0300;
  localparam wb_addr_t SUB_BASE     = 32'h0000_0400;

  // operations per test for sizing the watchdog
  localparam int OPS_RESET    = 1;
  localparam int OPS_WORD     = 64;
  localparam int OPS_SUBWORD  = 64;
  localparam int OPS_MISALIGN = 9;
  localparam int OPS_STREAM   = 32;
  localparam int OPS_REDIRECT = 10;
  localparam int OPS_ALIAS    = 8;
  localparam int TOTAL_OPS    = OPS_RESET + OPS_WORD + OPS_SUBWORD + OPS_MISALIGN
                                + OPS_STREAM + OPS_REDIRECT + OPS_ALIAS;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 10 + 8 + 100;

  logic     clk;
  logic     rst_i;
  logic     fetch_en_i;
  logic     redirect_i;
  wb_addr_t redirect_pc_i;
  logic     instr_valid_o;
  wb_data_t instr_o;
  wb_addr_t instr_pc_o;
  logic     req_i;
  lsu_op_e  lsu_op_i;
  wb_addr_t lsu_addr_i;
  wb_data_t lsu_wdata_i;
  logic     busy_o;
  logic     done_o;
  logic     lsu_err_o;
  wb_data_t lsu_rdata_o;

  // byte model of the RAM stays X until written
  logic [7:0]  ref_mem [MEM_BYTES];
  logic [31:0] rng_state;

  mem_subsys_top #(
    .ADDR_BITS (10),
    .RESET_PC  (32'h0)
  ) dut (
    .clk           (clk),
    .rst_i         (rst_i),
    .fetch_en_i    (fetch_en_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o),
    .req_i         (req_i),
    .lsu_op_i      (lsu_op_i),
    .lsu_addr_i    (lsu_addr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .lsu_err_o     (lsu_err_o),
    .lsu_rdata_o   (lsu_rdata_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // xorshift32 step
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // RAM aliases modulo its size
  function automatic int byte_index(wb_addr_t addr);
    return int'(addr % wb_addr_t'(MEM_BYTES));
  endfunction

  function automatic int access_bytes(lsu_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  // little endian with lowest address in lane 0
  function automatic void model_store(lsu_op_e op, wb_addr_t addr, wb_data_t data);
    for (int i = 0; i < access_bytes(op); i++)
      ref_mem[byte_index(addr + wb_addr_t'(i))] = data[8*i +: 8];
  endfunction

  function automatic wb_data_t model_load(lsu_op_e op, wb_addr_t addr);
    wb_data_t v;
    v = '0;
    for (int i = 0; i < access_bytes(op); i++)
      v[8*i +: 8] = ref_mem[byte_index(addr + wb_addr_t'(i))];
    // signed loads copy the top loaded bit upward
    if (op == LB)
      v = {{24{v[7]}}, v[7:0]};
    else if (op == LH)
      v = {{16{v[15]}}, v[15:0]};
    return v;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
  endtask

  // one request entered and left on a falling edge
  // latency counts cycles from req_i to done_o
  task automatic lsu_access(input string name, input lsu_op_e op, input wb_addr_t addr,
                            input wb_data_t wdata, output wb_data_t rdata,
                            output logic err, output int latency);
    int waited;
    req_i       = 1'b1;
    lsu_op_i    = op;
    lsu_addr_i  = addr;
    lsu_wdata_i = wdata;
    @(negedge clk);
    req_i  = 1'b0;
    // request taken so busy_o is up
    check_value($sformatf("%s busy_o high", name), 32'd1, {31'd0, busy_o});
    waited = 1;
    while (!done_o && waited < WAIT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!done_o)
      fail_run($sformatf("%s: done_o never arrived", name));
    else
    begin
      rdata   = lsu_rdata_o;
      err     = lsu_err_o;
      latency = waited;
      @(negedge clk);
      // busy_o drops the cycle after done_o
      check_value($sformatf("%s busy_o low", name), 32'd0, {31'd0, busy_o});
    end
  endtask

  task automatic do_store(input string name, input lsu_op_e op, input wb_addr_t addr,
                          input wb_data_t data);
    wb_data_t rdata;
    logic     err;
    int       latency;
    lsu_access(name, op, addr, data, rdata, err, latency);
    check_value($sformatf("%s err", name), 32'd0, {31'd0, err});
    check_value($sformatf("%s latency", name), 32'd2, 32'(latency));
    model_store(op, addr, data);
  endtask

  task automatic do_load(input string name, input lsu_op_e op, input wb_addr_t addr);
    wb_data_t rdata;
    logic     err;
    int       latency;
    lsu_access(name, op, addr, '0, rdata, err, latency);
    check_value($sformatf("%s err", name), 32'd0, {31'd0, err});
    check_value($sformatf("%s latency", name), 32'd2, 32'(latency));
    check_value($sformatf("%s %s @%h", name, op.name(), addr), model_load(op, addr), rdata);
  endtask

  // error with done_o one cycle after req_i and the model untouched
  task automatic do_misaligned(input string name, input lsu_op_e op, input wb_addr_t addr);
    wb_data_t rdata;
    logic     err;
    int       latency;
    lsu_access(name, op, addr, next_random(), rdata, err, latency);
    check_value($sformatf("%s err", name), 32'd1, {31'd0, err});
    check_value($sformatf("%s latency", name), 32'd1, 32'(latency));
  endtask

  // load the counter with fetch idle then enable streaming
  task automatic start_fetch(input wb_addr_t target);
    fetch_en_i    = 1'b0;
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    @(negedge clk);
    redirect_i = 1'b0;
    fetch_en_i = 1'b1;
  endtask

  task automatic stop_fetch();
    fetch_en_i = 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_instr(input string name, output wb_addr_t pc, output wb_data_t instr);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!instr_valid_o && waited < WAIT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!instr_valid_o)
      fail_run($sformatf("%s: instr_valid_o never arrived", name));
    else
    begin
      pc    = instr_pc_o;
      instr = instr_o;
    end
  endtask

  task automatic check_fetch(input string name, input wb_addr_t expected_pc);
    wb_addr_t pc;
    wb_data_t instr;
    wait_instr(name, pc, instr);
    check_value($sformatf("%s pc", name), expected_pc, pc);
    check_value($sformatf("%s instr @%h", name, pc), model_load(LW, expected_pc), instr);
  endtask

  task automatic test_reset_state();
    wb_addr_t pc;
    wb_data_t instr;
    check_value("reset busy_o", 32'd0, {31'd0, busy_o});
    check_value("reset done_o", 32'd0, {31'd0, done_o});
    check_value("reset lsu_err_o", 32'd0, {31'd0, lsu_err_o});
    check_value("reset instr_valid_o", 32'd0, {31'd0, instr_valid_o});
    // first fetch without redirect starts at RESET_PC
    fetch_en_i = 1'b1;
    wait_instr("reset pc", pc, instr);
    check_value("reset pc", 32'h0, pc);
    stop_fetch();
  endtask

  task automatic test_word_store_load();
    for (int i = 0; i < 32; i++)
      do_store("word_store_load", SW, wb_addr_t'(8 * i), next_random());
    for (int i = 0; i < 32; i++)
      do_load("word_store_load", LW, wb_addr_t'(8 * i));
  endtask

  task automatic test_subword();
    wb_addr_t word;
    for (int i = 0; i < 8; i++)
      do_store("subword", SW, SUB_BASE + wb_addr_t'(4 * i), next_random());
    for (int i = 0; i < 8; i++)
    begin
      word = SUB_BASE + wb_addr_t'(4 * i);
      // byte and halfword updates at rotating offsets
      do_store("subword", SB, word + wb_addr_t'(i % 4), next_random());
      do_store("subword", SH, word + wb_addr_t'(2 * ((i / 2) % 2)), next_random());
      do_load("subword", LB, word + wb_addr_t'((i + 1) % 4));
      do_load("subword", LBU, word + wb_addr_t'((i + 3) % 4));
      do_load("subword", LH, word + wb_addr_t'(2 * (i % 2)));
      do_load("subword", LHU, word + wb_addr_t'(2 * ((i + 1) % 2)));
      do_load("subword", LW, word);
    end
  endtask

  task automatic test_misaligned();
    do_store("misaligned", SW, MIS_BASE, next_random());
    do_store("misaligned", SW, MIS_BASE + 32'd4, next_random());
    do_misaligned("misaligned LH", LH, MIS_BASE + 32'd1);
    do_misaligned("misaligned SH", SH, MIS_BASE + 32'd3);
    do_misaligned("misaligned LW", LW, MIS_BASE + 32'd2);
    do_misaligned("misaligned SW", SW, MIS_BASE + 32'd1);
    do_misaligned("misaligned SW", SW, MIS_BASE + 32'd6);
    // both words must be as first written
    do_load("misaligned readback", LW, MIS_BASE);
    do_load("misaligned readback", LW, MIS_BASE + 32'd4);
  endtask

  task automatic test_fetch_stream();
    for (int i = 0; i < 16; i++)
      do_store("fetch_stream", SW, FETCH_BASE + wb_addr_t'(4 * i), next_random());
    start_fetch(FETCH_BASE);
    for (int i = 0; i < 16; i++)
      check_fetch("fetch_stream", FETCH_BASE + wb_addr_t'(4 * i));
    stop_fetch();
  endtask

  task automatic test_redirect();
    start_fetch(FETCH_BASE);
    for (int i = 0; i < 4; i++)
      check_fetch("redirect", FETCH_BASE + wb_addr_t'(4 * i));
    // redirect in the cycle the next sequential read goes out
    redirect_i    = 1'b1;
    redirect_pc_i = REDIR_TARGET;
    @(negedge clk);
    // that read comes back squashed
    check_value("redirect squash", 32'd0, {31'd0, instr_valid_o});
    redirect_i = 1'b0;
    for (int i = 0; i < 4; i++)
      check_fetch("redirect", REDIR_TARGET + wb_addr_t'(4 * i));
    stop_fetch();
  endtask

  task automatic test_alias();
    wb_data_t data;
    wb_data_t rdata;
    wb_addr_t pc;
    wb_data_t instr;
    logic     err;
    int       latency;
    data = next_random();
    do_store("alias", SW, ALIAS_HIGH, data);
    lsu_access("alias low", LW, ALIAS_LOW, '0, rdata, err, latency);
    check_value("alias low data", data, rdata);
    do_load("alias high", LW, ALIAS_HIGH);
    // same word through the instruction port at both addresses
    start_fetch(ALIAS_LOW);
    wait_instr("alias fetch low", pc, instr);
    check_value("alias fetch low pc", ALIAS_LOW, pc);
    check_value("alias fetch low instr", data, instr);
    stop_fetch();
    start_fetch(ALIAS_HIGH);
    wait_instr("alias fetch high", pc, instr);
    check_value("alias fetch high pc", ALIAS_HIGH, pc);
    check_value("alias fetch high instr", data, instr);
    stop_fetch();
  endtask

  initial
  begin
    rst_i         = 1'b1;
    fetch_en_i    = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    req_i         = 1'b0;
    lsu_op_i      = LW;
    lsu_addr_i    = '0;
    lsu_wdata_i   = '0;
    rng_state     = 32'd86;
    repeat (8) @(negedge clk);
    rst_i = 1'b0;
    @(negedge clk);
    test_reset_state();
    test_word_store_load();
    test_subword();
    test_misaligned();
    test_fetch_stream();
    test_redirect();
    test_alias();
    $display("No errors");
    $finish;
  end

  // run length bound from the operation count
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire

//--- hw/mem_subsys_top.sv
`default_nettype none

// memory side: fetch and load/store masters on a shared dual-port RAM
module mem_subsys_top
  import wishbone_pkg::*, lsu_pkg::*;
#(
  parameter int       ADDR_BITS = 10,
  parameter wb_addr_t RESET_PC  = '0
) (
  input  wire           clk,
  input  wire           rst_i,
  // fetch side
  input  wire           fetch_en_i,
  input  wire           redirect_i,
  input  wire wb_addr_t redirect_pc_i,
  output logic          instr_valid_o,
  output wb_data_t      instr_o,
  output wb_addr_t      instr_pc_o,
  // load/store side
  input  wire           req_i,
  input  wire lsu_op_e  lsu_op_i,
  input  wire wb_addr_t lsu_addr_i,
  input  wire wb_data_t lsu_wdata_i,
  output logic          busy_o,
  output logic          done_o,
  output logic          lsu_err_o,
  output wb_data_t      lsu_rdata_o
);

  // one bus per RAM port
  wishbone_if inst_bus ();
  wishbone_if data_bus ();

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk           (clk),
    .rst_i         (rst_i),
    .fetch_en_i    (fetch_en_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o),
    .bus           (inst_bus.master)
  );

  load_store_unit u_lsu (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .lsu_op_i    (lsu_op_i),
    .lsu_addr_i  (lsu_addr_i),
    .lsu_wdata_i (lsu_wdata_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .lsu_err_o   (lsu_err_o),
    .lsu_rdata_o (lsu_rdata_o),
    .bus         (data_bus.master)
  );

  wb_dual_ram #(
    .ADDR_BITS (ADDR_BITS)
  ) u_ram (
    .clk      (clk),
    .rst_i    (rst_i),
    .inst_bus (inst_bus.slave),
    .data_bus (data_bus.slave)
  );

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
`default_nettype none

// byte/halfword/word loads and stores onto the data bus
module load_store_unit
  import wishbone_pkg::*, lsu_pkg::*;
(
  input  wire           clk,
  input  wire           rst_i,
  input  wire           req_i,
  input  wire lsu_op_e  lsu_op_i,
  input  wire wb_addr_t lsu_addr_i,
  input  wire wb_data_t lsu_wdata_i,
  output logic          busy_o,
  output logic          done_o,
  output logic          lsu_err_o,
  output wb_data_t      lsu_rdata_o,
  wishbone_if.master    bus
);

  typedef enum logic [1:0] {IDLE, BUS, RESP} lsu_state_e;

  lsu_state_e state_q;
  lsu_state_e state_d;

  // captured request
  lsu_op_e  op_q;
  wb_addr_t addr_q;
  wb_data_t wdata_q;

  logic [1:0]           size;
  logic [WB_OFFS_W-1:0] offs;
  logic                 misaligned;
  wb_sel_t              sel;
  wb_data_t             store_data;
  wb_data_t             shifted;

  assign size = lsu_size(op_q);
  assign offs = addr_q[WB_OFFS_W-1:0];

  // alignment, lanes and replicated store data
  always_comb
  begin
    case (size)
      LSU_SIZE_B:
      begin
        misaligned = 1'b0;
        sel        = wb_sel_t'(1) << offs;
        store_data = {4{wdata_q[7:0]}};
      end
      LSU_SIZE_H:
      begin
        misaligned = offs[0];
        sel        = wb_sel_t'(3) << {offs[1], 1'b0};
        store_data = {2{wdata_q[15:0]}};
      end
      default:
      begin
        misaligned = |offs;
        sel        = WB_SEL_ALL;
        store_data = wdata_q;
      end
    endcase
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_i) state_d = BUS;
      // misaligned requests skip the bus
      BUS:     state_d = misaligned ? IDLE : RESP;
      RESP:    if (bus.ack) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk)
  begin
    if (state_q == IDLE && req_i)
    begin
      op_q    <= lsu_op_i;
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
  end

  assign bus.cyc   = (state_q == BUS) && !misaligned;
  assign bus.stb   = bus.cyc;
  assign bus.we    = lsu_is_store(op_q);
  assign bus.adr   = addr_q;
  assign bus.sel   = sel;
  assign bus.dat_w = store_data;

  // addressed lanes down to bit 0, then extend
  assign shifted = bus.dat_r >> {offs, 3'b000};

  always_comb
  begin
    case (size)
      LSU_SIZE_B:
        lsu_rdata_o = lsu_is_signed(op_q) ? {{24{shifted[7]}}, shifted[7:0]}
                                          : {24'b0, shifted[7:0]};
      LSU_SIZE_H:
        lsu_rdata_o = lsu_is_signed(op_q) ? {{16{shifted[15]}}, shifted[15:0]}
                                          : {16'b0, shifted[15:0]};
      default:
        lsu_rdata_o = shifted;
    endcase
  end

  assign busy_o    = state_q != IDLE;
  assign lsu_err_o = (state_q == BUS) && misaligned;
  assign done_o    = lsu_err_o || (state_q == RESP && bus.ack);

  // core side must hold off while a request is open
  a_no_req_when_busy: assert property (@(posedge clk) disable iff (rst_i)
    busy_o |-> !req_i)
    else $error("load/store request while busy");

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`default_nettype none

// sequential instruction fetch, one word read per cycle
module fetch_unit
  import wishbone_pkg::*;
#(
  parameter wb_addr_t RESET_PC = '0
) (
  input  wire           clk,
  input  wire           rst_i,
  input  wire           fetch_en_i,
  input  wire           redirect_i,
  input  wire wb_addr_t redirect_pc_i,
  output logic          instr_valid_o,
  output wb_data_t      instr_o,
  output wb_addr_t      instr_pc_o,
  wishbone_if.master    bus
);

  wb_addr_t pc_q;
  // address and squash flag of the request in flight
  wb_addr_t flight_pc_q;
  logic     flight_squash_q;
  logic     issue;

  // slave never stalls so issue whenever enabled
  assign issue = fetch_en_i;

  assign bus.cyc   = issue;
  assign bus.stb   = issue;
  assign bus.we    = 1'b0;
  assign bus.adr   = pc_q;
  assign bus.sel   = WB_SEL_ALL;
  assign bus.dat_w = '0;

  // program counter
  always_ff @(posedge clk)
  begin
    if (rst_i)
      pc_q <= RESET_PC;
    else if (redirect_i)
      pc_q <= redirect_pc_i;
    else if (issue)
      pc_q <= pc_q + wb_addr_t'(WB_SEL_W);
  end

  // read issued alongside a redirect is stale, drop its response
  always_ff @(posedge clk)
  begin
    if (rst_i)
      flight_squash_q <= 1'b0;
    else if (issue)
      flight_squash_q <= redirect_i;
  end

  always_ff @(posedge clk)
  begin
    if (issue)
      flight_pc_q <= pc_q;
  end

  // pair each ack with its address
  assign instr_valid_o = bus.ack & ~flight_squash_q;
  assign instr_o       = bus.dat_r;
  assign instr_pc_o    = flight_pc_q;

  // RAM answers only requests this unit issued, one cycle late
  a_ack_follows_req: assert property (@(posedge clk) disable iff (rst_i)
    bus.ack |-> $past(issue))
    else $error("instruction ack without request");

endmodule

`default_nettype wire

//--- hw/wb_dual_ram.sv
`default_nettype none

// dual-port RAM, one byte array per lane
// instruction port read only, data port read/write
module wb_dual_ram
  import wishbone_pkg::*;
#(
  parameter int ADDR_BITS = 10
) (
  input  wire       clk,
  input  wire       rst_i,
  wishbone_if.slave inst_bus,
  wishbone_if.slave data_bus
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  // word index, upper address bits dropped so addresses alias
  logic [ADDR_BITS-1:0] inst_idx;
  logic [ADDR_BITS-1:0] data_idx;
  logic                 inst_xfer;
  logic                 data_xfer;

  // registered read lanes
  logic [WB_LANE_W-1:0] inst_byte_q [WB_SEL_W];
  logic [WB_LANE_W-1:0] data_byte_q [WB_SEL_W];

  assign inst_idx  = inst_bus.adr[ADDR_BITS+1:2];
  assign data_idx  = data_bus.adr[ADDR_BITS+1:2];
  assign inst_xfer = inst_bus.cyc & inst_bus.stb;
  assign data_xfer = data_bus.cyc & data_bus.stb;

  for (genvar l = 0; l < WB_SEL_W; l++)
  begin : g_lane
    logic [WB_LANE_W-1:0] mem [DEPTH];

    always_ff @(posedge clk)
    begin
      // write only the selected lane
      if (data_xfer && data_bus.we && data_bus.sel[l])
      begin
        mem[data_idx] <= data_bus.dat_w[WB_LANE_W*l +: WB_LANE_W];
      end
      // reads see the old word, deselected lanes return zero
      inst_byte_q[l] <= {WB_LANE_W{inst_bus.sel[l]}} & mem[inst_idx];
      data_byte_q[l] <= {WB_LANE_W{data_bus.sel[l]}} & mem[data_idx];
    end
  end

  // pack lanes back into words
  always_comb
  begin
    for (int l = 0; l < WB_SEL_W; l++)
    begin
      inst_bus.dat_r[WB_LANE_W*l +: WB_LANE_W] = inst_byte_q[l];
      data_bus.dat_r[WB_LANE_W*l +: WB_LANE_W] = data_byte_q[l];
    end
  end

  // ack one cycle after each transfer, never stalls
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      inst_bus.ack <= 1'b0;
      data_bus.ack <= 1'b0;
    end
    else
    begin
      inst_bus.ack <= inst_xfer;
      data_bus.ack <= data_xfer;
    end
  end

  // fetch master must never write through the instruction port
  a_inst_read_only: assert property (@(posedge clk) disable iff (rst_i)
    inst_xfer |-> !inst_bus.we)
    else $error("write on instruction port");

endmodule

`default_nettype wire

//--- hw/wishbone_if.sv
`default_nettype none

// classic wishbone strobes, no tags, no stall/err/rty
interface wishbone_if
  import wishbone_pkg::*;
();

  // master side
  logic     cyc;
  logic     stb;
  logic     we;
  wb_addr_t adr;
  wb_sel_t  sel;
  wb_data_t dat_w;

  // slave side
  wb_data_t dat_r;
  logic     ack;

  modport master (
    output cyc, stb, we, adr, sel, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, sel, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

//--- hw/lsu_pkg.sv
`default_nettype none

// load/store opcodes and size helpers
package lsu_pkg;

  // access size codes
  localparam logic [1:0] LSU_SIZE_B = 2'd0;
  localparam logic [1:0] LSU_SIZE_H = 2'd1;
  localparam logic [1:0] LSU_SIZE_W = 2'd2;

  // memory opcodes, loads first then stores
  typedef enum logic [2:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } lsu_op_e;

  // access size of an opcode
  function automatic logic [1:0] lsu_size(lsu_op_e op);
    case (op)
      LB, LBU, SB: return LSU_SIZE_B;
      LH, LHU, SH: return LSU_SIZE_H;
      default:     return LSU_SIZE_W;
    endcase
  endfunction

  // store group
  function automatic logic lsu_is_store(lsu_op_e op);
    return op inside {SB, SH, SW};
  endfunction

  // sign-extending loads
  function automatic logic lsu_is_signed(lsu_op_e op);
    return op inside {LB, LH};
  endfunction

endpackage

`default_nettype wire

//--- hw/wishbone_pkg.sv
`default_nettype none

// shared wishbone bus widths and types
package wishbone_pkg;

  // byte address and data word widths
  localparam int WB_ADDR_W = 32;
  localparam int WB_DATA_W = 32;

  // one select bit per byte lane
  localparam int WB_LANE_W = 8;
  localparam int WB_SEL_W  = WB_DATA_W / WB_LANE_W;

  // byte address, full 32 bits on the bus
  typedef logic [WB_ADDR_W-1:0] wb_addr_t;

  // bus data word
  typedef logic [WB_DATA_W-1:0] wb_data_t;

  // lane select, bit n covers bits 8n+7 down to 8n
  typedef logic [WB_SEL_W-1:0] wb_sel_t;

  // all lanes on, used for whole-word reads
  localparam wb_sel_t WB_SEL_ALL = '1;

  // byte offset bits inside one word
  localparam int WB_OFFS_W = $clog2(WB_SEL_W);

endpackage

`default_nettype wire
